/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP        = sauTb
FILELIST   = sim.f
BUILD      = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD)/V$(TOP): $(FILELIST) $(wildcard verilog/*.sv) $(wildcard test/*.sv) $(wildcard include/*.svh)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(BUILD)

/* sim.f */
+incdir+include
verilog/sauPkg.sv
verilog/sauShifter.sv
verilog/sauBitCount.sv
verilog/sauChecker.sv
verilog/sauExecute.sv
verilog/sauTop.sv
test/sauTb.sv

/* include/sauVectors.svh */
`ifndef SAU_VECTORS_SVH
`define SAU_VECTORS_SVH

// One issued operation and what it must produce one cycle later
typedef struct packed {
	opcode_t opcode;
	func_t func;
	logic [2:0] op3;
	logic [DefaultWidth-1:0] a;
	logic [DefaultWidth-1:0] b;
	logic [DefaultWidth-1:0] c;
	logic [DefaultWidth-1:0] imm;
	logic [7:0] cpl;
	logic [DefaultWidth-1:0] canary;
	logic [DefaultWidth-1:0] expO;
	cause_t expExc;
} vector_t;

localparam logic [DefaultWidth-1:0] VecOnes = '1;
localparam logic [DefaultWidth-1:0] VecMsb = {1'b1, {(DefaultWidth-1){1'b0}}};
localparam logic [DefaultWidth-1:0] VecDead = {(DefaultWidth/16){16'hDEAD}};

localparam int NumVectors = 54;

// opcode, func, op3, a, b, c, imm, cpl, canary, expO, expExc
localparam vector_t Vectors [NumVectors] = '{
	'{OP_R3O, FN_ADD, 3'd0, 'h10, 'h5, 'hF, 0, 0, 0, 'h5, FLT_NONE},
	'{OP_R3O, FN_ADD, 3'd3, 100, 23, 7, 0, 0, 0, 130, FLT_NONE},
	'{OP_R3O, FN_SUB, 3'd3, 100, 23, 7, 0, 0, 0, 70, FLT_NONE},
	'{OP_R3O, FN_SUB, 3'd1, 'h30, 'h10, 'h1, 0, 0, 0, 'h21, FLT_NONE},
	'{OP_R3O, FN_XOR, 3'd2, 'hFF00, 'h0FF0, 'h000F, 0, 0, 0, 'hF0FF, FLT_NONE},
	'{OP_R3O, FN_AND, 3'd5, VecOnes, VecOnes, 0, 0, 0, 0, 0, FLT_NONE},
	'{OP_R3O, FN_OR, 3'd7, 'h1, 'h2, 'h4, 0, 0, 0, 0, FLT_NONE},
	'{OP_R3O, FN_SLT, 3'd1, VecOnes, 1, 0, 0, 0, 0, 1, FLT_NONE},
	'{OP_R3O, FN_SLTU, 3'd1, VecOnes, 1, 8, 0, 0, 0, 8, FLT_NONE},
	'{OP_R3O, FN_SEQ, 3'd3, 5, 5, 1, 0, 0, 0, 2, FLT_NONE},
	'{OP_R3O, FN_SLE, 3'd0, 5, 5, 1, 0, 0, 0, 1, FLT_NONE},
	'{OP_R3O, FN_SLEU, 3'd3, 7, 5, 2, 0, 0, 0, 2, FLT_NONE},
	'{OP_R3O, FN_ASL, 3'd3, 3, 1, 1, 0, 0, 0, 7, FLT_NONE},
	'{OP_R3O, FN_ASL, 3'd1, 1, 63, 0, 0, 0, 0, VecMsb, FLT_NONE},
	'{OP_R3O, FN_ASR, 3'd1, VecMsb, 4, 0, 0, 0, 0, {5'h1F, 59'd0}, FLT_NONE},
	'{OP_R3O, FN_ASR, 3'd0, VecMsb, 63, VecOnes, 0, 0, 0, VecOnes, FLT_NONE},
	'{OP_R3O, FN_LSR, 3'd2, VecMsb, 1, {2'b01, 62'd1}, 0, 0, 0, 1, FLT_NONE},
	'{OP_R3O, FN_ROL, 3'd1, 'h1234, 64, 0, 0, 0, 0, 'h1234, FLT_NONE},
	'{OP_R3O, FN_ROL, 3'd1, VecMsb, 1, 0, 0, 0, 0, 1, FLT_NONE},
	'{OP_R3O, FN_ROR, 3'd1, 1, 1, 0, 0, 0, 0, VecMsb, FLT_NONE},
	'{OP_R3O, FN_ROR, 3'd1, 1, 63, 0, 0, 0, 0, 2, FLT_NONE},
	'{OP_R3O, FN_MOVE, 3'd7, 0, 'hCAFE, 1, 0, 0, 0, 'hCAFE, FLT_NONE},
	'{OP_R3O, FN_R1, 3'd0, 0, 0, 0, 0, 0, 0, 64, FLT_NONE},
	'{OP_R3O, FN_R1, 3'd3, 0, 0, 0, 0, 0, 0, 64, FLT_NONE},
	'{OP_R3O, FN_R1, 3'd1, VecOnes, 0, 0, 0, 0, 0, 64, FLT_NONE},
	'{OP_R3O, FN_R1, 3'd2, VecOnes, 0, 0, 0, 0, 0, 64, FLT_NONE},
	'{OP_R3O, FN_R1, 3'd0, 'h100, 0, 0, 0, 0, 0, 55, FLT_NONE},
	'{OP_R3O, FN_R1, 3'd3, 'h100, 0, 0, 0, 0, 0, 8, FLT_NONE},
	'{OP_R3O, FN_R1, 3'd2, {4'hF, 60'd0}, 0, 0, 0, 0, 0, 4, FLT_NONE},
	'{OP_ADDI, FN_ADD, 3'd0, 10, 0, 0, VecOnes - 2, 0, 0, 7, FLT_NONE},
	'{OP_ANDI, FN_ADD, 3'd0, 'hFF, 0, 0, 'h3C, 0, 0, 'h3C, FLT_NONE},
	'{OP_ORI, FN_ADD, 3'd0, 'hF0, 0, 0, 'h0F, 0, 0, 'hFF, FLT_NONE},
	'{OP_XORI, FN_ADD, 3'd0, 'hFF, 0, 0, 'h0F, 0, 0, 'hF0, FLT_NONE},
	'{OP_SUBFI, FN_ADD, 3'd0, 5, 0, 0, 20, 0, 0, 15, FLT_NONE},
	'{OP_NOP, FN_ADD, 3'd0, 5, 6, 7, 8, 0, 0, 0, FLT_NONE},
	'{opcode_t'(7'h7E), FN_ADD, 3'd0, 5, 6, 7, 8, 0, 0, VecDead, FLT_NONE},
	'{OP_CHK, func_t'(6'd0), 3'd0, 5, 5, 10, 0, 0, 0, 0, FLT_NONE},
	'{OP_CHK, func_t'(6'd0), 3'd0, 10, 5, 10, 0, 0, 0, 0, FLT_CHK},
	'{OP_CHK, func_t'(6'd1), 3'd0, 10, 5, 10, 0, 0, 0, 0, FLT_NONE},
	'{OP_CHK, func_t'(6'd2), 3'd0, 5, 5, 10, 0, 0, 0, 0, FLT_CHK},
	'{OP_CHK, func_t'(6'd3), 3'd0, 10, 5, 10, 0, 0, 0, 0, FLT_NONE},
	'{OP_CHK, func_t'(6'd3), 3'd0, 5, 5, 10, 0, 0, 0, 0, FLT_CHK},
	'{OP_CHK, func_t'(6'd4), 3'd0, 4, 5, 10, 0, 0, 0, 0, FLT_NONE},
	'{OP_CHK, func_t'(6'd4), 3'd0, 5, 5, 10, 0, 0, 0, 0, FLT_CHK},
	'{OP_CHK, func_t'(6'd5), 3'd0, 11, 5, 10, 0, 0, 0, 0, FLT_NONE},
	'{OP_CHK, func_t'(6'd6), 3'd0, 7, 5, 10, 0, 0, 0, 0, FLT_CHK},
	'{OP_CHK, func_t'(6'd7), 3'd0, 10, 5, 10, 0, 0, 0, 0, FLT_CHK},
	'{OP_CHK, func_t'(6'd8), 3'd0, 3, 0, 0, 0, 3, 0, 0, FLT_NONE},
	'{OP_CHK, func_t'(6'd8), 3'd0, 2, 0, 0, 0, 3, 0, 0, FLT_CHK},
	'{OP_CHK, func_t'(6'd9), 3'd0, 4, 0, 0, 0, 3, 0, 0, FLT_CHK},
	'{OP_CHK, func_t'(6'd9), 3'd0, 3, 0, 0, 0, 3, 0, 0, FLT_NONE},
	'{OP_CHK, func_t'(6'd10), 3'd0, 'h5A5B, 0, 0, 0, 0, 'h5A5A, 0, FLT_CHK},
	'{OP_CHK, func_t'(6'd10), 3'd0, 'h5A5A, 0, 0, 0, 0, 'h5A5A, 0, FLT_NONE},
	'{OP_CHK, func_t'(6'd15), 3'd0, 0, 0, 0, 0, 0, 0, 0, FLT_UNIMP}
};

`endif

/* test/sauTb.sv */
`default_nettype none

module sauTb import sauPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	`include "sauVectors.svh"

	localparam int W = DefaultWidth;
	localparam int AmtW = $clog2(W);
	localparam int NumRandom = 40;
	localparam int TimeoutCycles = (NumVectors + NumRandom + 3 + 10) * 2;
	localparam func_t RandFuncs [18] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_ASL,
		FN_LSR, FN_ASR, FN_ROL, FN_ROR, FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU,
		FN_MOVE, FN_R1};

	logic clk = 1'b0;
	logic rst;
	logic inValid;
	opcode_t opcode;
	func_t func;
	logic [2:0] op3;
	logic [W-1:0] a;
	logic [W-1:0] b;
	logic [W-1:0] c;
	logic [W-1:0] imm;
	logic [W-1:0] canary;
	logic [7:0] cpl;
	logic outValid;
	logic [W-1:0] o;
	cause_t excOut;

	int cycles = 0;
	int passCount = 0;
	int failCount = 0;
	logic [W-1:0] lastO = '0;

	// Operations in flight with the oldest first
	logic [W-1:0] expOQ[$];
	cause_t expExcQ[$];
	int dueQ[$];
	string labelQ[$];

	sauTop #(.Width(W)) uut (.clk(clk), .rst(rst), .inValid(inValid), .opcode(opcode),
		.func(func), .op3(op3), .a(a), .b(b), .c(c), .imm(imm), .cpl(cpl), .canary(canary),
		.outValid(outValid), .o(o), .excOut(excOut));

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TimeoutCycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// ==================================================
	// Reference model
	// ==================================================
	function automatic logic [W-1:0] countOf(logic [2:0] sel, logic [W-1:0] x);
		int lz;
		int lo;
		int tz;
		int pop;
		lz = 0;
		lo = 0;
		tz = 0;
		pop = 0;
		while (lz < W && !x[W-1-lz]) lz++;	// Scan from the top
		while (lo < W && x[W-1-lo]) lo++;
		while (tz < W && !x[tz]) tz++;
		for (int i = 0; i < W; i++)
			pop += x[i];
		case (sel)
		3'd0: return W'(lz);
		3'd1: return W'(pop);
		3'd2: return W'(lo);
		3'd3: return W'(tz);
		default: return '0;
		endcase
	endfunction

	function automatic logic [W-1:0] model(func_t f, logic [2:0] sel, logic [W-1:0] x,
		logic [W-1:0] y, logic [W-1:0] z);
		logic [W-1:0] raw;
		logic [W-1:0] msb;
		int s;
		s = int'(y[AmtW-1:0]);
		msb = {1'b1, {(W-1){1'b0}}};
		if (f == FN_MOVE)
			return y;
		if (f == FN_R1)
			return countOf(sel, x);
		case (f)
		FN_ADD:  raw = x + y;
		FN_SUB:  raw = x - y;
		FN_AND:  raw = x & y;
		FN_OR:   raw = x | y;
		FN_XOR:  raw = x ^ y;
		FN_ASL:  raw = x << s;
		FN_LSR:  raw = x >> s;
		FN_ASR:  raw = (x >> s) | (x[W-1] ? ~({W{1'b1}} >> s) : '0);
		FN_ROL:  raw = (s == 0) ? x : (x << s) | (x >> (W - s));
		FN_ROR:  raw = (s == 0) ? x : (x >> s) | (x << (W - s));
		FN_SEQ:  raw = (x == y) ? 1 : 0;
		FN_SNE:  raw = (x != y) ? 1 : 0;
		FN_SLT:  raw = ((x ^ msb) < (y ^ msb)) ? 1 : 0;	// Flipped sign bit orders signed values
		FN_SLE:  raw = ((x ^ msb) <= (y ^ msb)) ? 1 : 0;
		FN_SLTU: raw = (x < y) ? 1 : 0;
		FN_SLEU: raw = (x <= y) ? 1 : 0;
		default: raw = '0;
		endcase
		case (sel)
		3'd0: return raw & z;
		3'd1: return raw | z;
		3'd2: return raw ^ z;
		3'd3: return (f == FN_SUB) ? raw - z : raw + z;
		default: return '0;
		endcase
	endfunction

	// ==================================================
	// Drive and check
	// ==================================================
	task automatic checkValue(string sig, logic [W-1:0] got, logic [W-1:0] exp, inout bit ok);
		assert (got === exp)
		else
		begin
			$display("ERR %0t ns: %s got %h expected %h", $time, sig, got, exp);
			ok = 1'b0;
		end
	endtask

	task automatic reportTest(string label, bit ok);
		if (ok)
		begin
			$display("%s ok", label);
			passCount++;
		end
		else
		begin
			$display("%s FAILED", label);
			failCount++;
		end
	endtask

	task automatic issue(vector_t v, string label);
		@(posedge clk);
		inValid <= 1'b1;
		opcode <= v.opcode;
		func <= v.func;
		op3 <= v.op3;
		a <= v.a;
		b <= v.b;
		c <= v.c;
		imm <= v.imm;
		cpl <= v.cpl;
		canary <= v.canary;
		expOQ.push_back(v.expO);
		expExcQ.push_back(v.expExc);
		dueQ.push_back(cycles + 2);	// Sampled on the next edge and checked half a cycle later
		labelQ.push_back(label);
		lastO = v.expO;
	endtask

	always @(negedge clk)
	begin
		bit ok;
		if (!rst && outValid)
		begin
			if (labelQ.size() == 0)
			begin
				$display("A result appeared at %0t ns with no operation in flight", $time);
				failCount++;
			end
			else
			begin
				ok = 1'b1;
				assert (cycles == dueQ[0])
				else
				begin
					$display("%s came out in cycle %0d instead of cycle %0d", labelQ[0],
						cycles, dueQ[0]);
					ok = 1'b0;
				end
				checkValue("o", o, expOQ.pop_front(), ok);
				checkValue("excOut", W'(excOut), W'(expExcQ.pop_front()), ok);
				void'(dueQ.pop_front());
				reportTest(labelQ.pop_front(), ok);
			end
		end
		else if (!rst && labelQ.size() != 0 && cycles >= dueQ[0])
		begin
			$display("%s gave no result in its cycle", labelQ[0]);
			failCount++;
			void'(expOQ.pop_front());
			void'(expExcQ.pop_front());
			void'(dueQ.pop_front());
			void'(labelQ.pop_front());
		end
	end

	initial
	begin
		vector_t v;
		bit ok;
		void'($urandom(13289));
		rst = 1'b1;
		inValid = 1'b0;
		opcode = OP_NOP;
		func = FN_ADD;
		op3 = '0;
		{a, b, c, imm, canary} = '0;
		cpl = '0;

		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		ok = 1'b1;
		checkValue("outValid", W'(outValid), '0, ok);
		checkValue("o", o, '0, ok);
		checkValue("excOut", W'(excOut), W'(FLT_NONE), ok);
		reportTest("reset state", ok);

		for (int i = 0; i < NumVectors; i++)
			issue(Vectors[i], $sformatf("vector %0d", i));

		// Register-form operations with random operands issued back to back
		for (int n = 0; n < NumRandom; n++)
		begin
			v = '0;
			v.opcode = OP_R3O;
			v.func = RandFuncs[$urandom % 18];
			v.op3 = 3'($urandom);
			v.a = {$urandom, $urandom};
			v.b = {$urandom, $urandom};
			v.c = {$urandom, $urandom};
			v.expO = model(v.func, v.op3, v.a, v.b, v.c);
			v.expExc = FLT_NONE;
			issue(v, $sformatf("random %0d", n));
		end

		@(posedge clk);
		inValid <= 1'b0;
		while (labelQ.size() != 0)
			@(posedge clk);
		@(negedge clk);
		ok = 1'b1;
		checkValue("outValid", W'(outValid), '0, ok);
		checkValue("o", o, lastO, ok);	// Held from the last result
		checkValue("excOut", W'(excOut), W'(FLT_NONE), ok);
		reportTest("idle hold", ok);

		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if (failCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/sauBitCount.sv */
`default_nettype none

module sauBitCount import sauPkg::*; #(
	parameter int Width = DefaultWidth
)(
	input  logic [Width-1:0] a,
	output logic [$clog2(Width):0] lzCnt,
	output logic [$clog2(Width):0] loCnt,
	output logic [$clog2(Width):0] tzCnt,
	output logic [$clog2(Width):0] popCnt
);

	localparam int CntW = $clog2(Width) + 1;

	// One pass from bit 0 upward where the last hit in each scan wins
	always_comb
	begin
		lzCnt = CntW'(Width);	// Stays Width when a has no set bit
		loCnt = CntW'(Width);
		tzCnt = CntW'(Width);
		popCnt = '0;
		for (int i = 0; i < Width; i++)
		begin
			if (a[i])
				lzCnt = CntW'(Width - 1 - i);	// Highest set bit
			else
				loCnt = CntW'(Width - 1 - i);	// Highest clear bit
			if (a[Width - 1 - i])
				tzCnt = CntW'(Width - 1 - i);	// Scanned downward so the lowest set bit wins
			popCnt = popCnt + CntW'(a[i]);
		end

		// Set bits fit between the leading and trailing zeros
		if (!$isunknown(a) && a != '0)
		begin
			assert (int'(popCnt) + int'(lzCnt) + int'(tzCnt) <= Width)
				else $error("sauBitCount: popCnt %0d overlaps lz %0d and tz %0d for a=%h",
					popCnt, lzCnt, tzCnt, a);
		end
	end

endmodule

`default_nettype wire

/* verilog/sauChecker.sv */
`default_nettype none

module sauChecker import sauPkg::*; #(
	parameter int Width = DefaultWidth
)(
	input  opcode_t opcode,
	input  func_t func,
	input  logic [Width-1:0] a,
	input  logic [Width-1:0] b,
	input  logic [Width-1:0] c,
	input  logic [Width-1:0] canary,
	input  logic [7:0] cpl,
	output cause_t chkCause
);

	logic [3:0] chkOp;
	logic [Width-1:0] cplExt;
	logic aboveLow;
	logic belowHigh;
	logic inRange;

	assign chkOp = func[3:0];
	assign cplExt = Width'(cpl);	// Privilege level compared as a plain number

	// Bounds of codes 0..3, reused by 4..7 through chkOp[1:0]
	assign aboveLow = chkOp[1] ? (a > b) : (a >= b);
	assign belowHigh = chkOp[0] ? (a <= c) : (a < c);
	assign inRange = aboveLow && belowHigh;

	always_comb
	begin
		chkCause = FLT_NONE;
		if (opcode == OP_CHK)
		begin
			if (chkOp[3:2] == CHK_RANGE_IN[3:2])
				chkCause = inRange ? FLT_NONE : FLT_CHK;
			else if (chkOp[3:2] == CHK_RANGE_OUT[3:2])
				chkCause = inRange ? FLT_CHK : FLT_NONE;
			else if (chkOp == CHK_CPL_GE)
				chkCause = (a >= cplExt) ? FLT_NONE : FLT_CHK;
			else if (chkOp == CHK_CPL_LE)
				chkCause = (a <= cplExt) ? FLT_NONE : FLT_CHK;
			else if (chkOp == CHK_CANARY)
				chkCause = (a == canary) ? FLT_NONE : FLT_CHK;	// Stack smash test
			else
				chkCause = FLT_UNIMP;
		end
	end

endmodule

`default_nettype wire

/* verilog/sauExecute.sv */
`default_nettype none

module sauExecute import sauPkg::*; #(
	parameter int Width = DefaultWidth
)(
	input  logic clk,
	input  logic rst,
	input  logic inValid,
	input  opcode_t opcode,
	input  func_t func,
	input  logic [2:0] op3,
	input  logic [Width-1:0] a,
	input  logic [Width-1:0] b,
	input  logic [Width-1:0] c,
	input  logic [Width-1:0] imm,
	input  logic [Width-1:0] shl,
	input  logic [Width-1:0] lsr,
	input  logic [Width-1:0] asr,
	input  logic [Width-1:0] rol,
	input  logic [Width-1:0] ror,
	input  logic [$clog2(Width):0] lzCnt,
	input  logic [$clog2(Width):0] loCnt,
	input  logic [$clog2(Width):0] tzCnt,
	input  logic [$clog2(Width):0] popCnt,
	input  cause_t chkCause,
	output logic outValid,
	output logic [Width-1:0] o,
	output cause_t excOut
);

	localparam logic [Width-1:0] Filler = {(Width/16){16'hDEAD}};

	logic [Width-1:0] raw;
	logic [Width-1:0] combined;
	logic [Width-1:0] count;
	logic [Width-1:0] result;
	logic rawKnown;

	// ==================================================
	// Register-form functions
	// ==================================================
	always_comb
	begin
		rawKnown = 1'b1;
		case (func)
		FN_ADD:  raw = a + b;
		FN_SUB:  raw = a - b;
		FN_AND:  raw = a & b;
		FN_OR:   raw = a | b;
		FN_XOR:  raw = a ^ b;
		FN_ASL:  raw = shl;
		FN_LSR:  raw = lsr;
		FN_ASR:  raw = asr;
		FN_ROL:  raw = rol;
		FN_ROR:  raw = ror;
		FN_SEQ:  raw = Width'(a == b);
		FN_SNE:  raw = Width'(a != b);
		FN_SLT:  raw = Width'($signed(a) < $signed(b));
		FN_SLE:  raw = Width'($signed(a) <= $signed(b));
		FN_SLTU: raw = Width'(a < b);
		FN_SLEU: raw = Width'(a <= b);
		default:
		begin
			raw = '0;
			rawKnown = 1'b0;	// MOVE, R1 and unassigned codes
		end
		endcase
	end

	// Fold c into the raw value
	always_comb
	begin
		case (combine_t'(op3))
		CMB_AND: combined = raw & c;
		CMB_OR:  combined = raw | c;
		CMB_XOR: combined = raw ^ c;
		CMB_ADD: combined = (func == FN_SUB) ? raw - c : raw + c;
		default: combined = '0;
		endcase
	end

	always_comb
	begin
		case (countSel_t'(op3))
		CNT_LZ:  count = Width'(lzCnt);
		CNT_POP: count = Width'(popCnt);
		CNT_LO:  count = Width'(loCnt);
		CNT_TZ:  count = Width'(tzCnt);
		default: count = '0;
		endcase
	end

	// ==================================================
	// Result select
	// ==================================================
	always_comb
	begin
		case (opcode)
		OP_R3O:
		begin
			if (func == FN_MOVE)
				result = b;	// op3 has no effect on a move
			else if (func == FN_R1)
				result = count;
			else if (rawKnown)
				result = combined;
			else
				result = '0;
		end
		OP_ADDI:  result = a + imm;
		OP_ANDI:  result = a & imm;
		OP_ORI:   result = a | imm;
		OP_XORI:  result = a ^ imm;
		OP_SUBFI: result = imm - a;
		OP_CHK:   result = '0;	// Only the cause matters
		OP_NOP:   result = '0;
		default:  result = Filler;
		endcase
	end

	// ==================================================
	// Output stage
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			outValid <= 1'b0;
			o <= '0;
			excOut <= FLT_NONE;
		end
		else
		begin
			outValid <= inValid;
			if (inValid)
			begin
				o <= result;
				excOut <= chkCause;
			end
			else
				excOut <= FLT_NONE;	// o holds its last value
		end
	end

	// No stale cause may be seen on an idle cycle
	idleNoCause: assert property (@(posedge clk) disable iff (rst)
		!outValid |-> excOut == FLT_NONE)
		else $error("sauExecute: excOut %0h while outValid is low", excOut);

	// Only a CHK issue may raise a cause in the following cycle
	causeOnlyFromChk: assert property (@(posedge clk) disable iff (rst)
		inValid && opcode != OP_CHK |=> excOut == FLT_NONE)
		else $error("sauExecute: cause %0h raised by a non-CHK operation", excOut);

endmodule

`default_nettype wire

/* verilog/sauPkg.sv */
`default_nettype none

package sauPkg;

	// ==================================================
	// Widths
	// ==================================================
	localparam int DefaultWidth = 64;

	// ==================================================
	// Instruction fields
	// ==================================================
	typedef enum logic [6:0] {
		OP_R3O   = 7'h02,	// Register form, func and op3 select
		OP_ADDI  = 7'h04,
		OP_SUBFI = 7'h05,	// imm - a
		OP_ANDI  = 7'h08,
		OP_ORI   = 7'h09,
		OP_XORI  = 7'h0A,
		OP_CHK   = 7'h0B,	// Check code in func[3:0]
		OP_NOP   = 7'h7F
	} opcode_t;

	typedef enum logic [5:0] {
		FN_AND  = 6'd0,
		FN_OR   = 6'd1,
		FN_XOR  = 6'd2,
		FN_ADD  = 6'd4,
		FN_SUB  = 6'd5,
		FN_SEQ  = 6'd8,
		FN_SNE  = 6'd9,
		FN_SLT  = 6'd10,
		FN_SLE  = 6'd11,
		FN_SLTU = 6'd12,
		FN_SLEU = 6'd13,
		FN_ASL  = 6'd16,
		FN_LSR  = 6'd17,
		FN_ASR  = 6'd18,
		FN_ROL  = 6'd19,
		FN_ROR  = 6'd20,
		FN_MOVE = 6'd24,
		FN_R1   = 6'd25	// Bit counts of a, op3 picks which
	} func_t;

	// How op3 folds c into a register-form result
	typedef enum logic [2:0] {
		CMB_AND = 3'd0,
		CMB_OR  = 3'd1,
		CMB_XOR = 3'd2,
		CMB_ADD = 3'd3	// FN_SUB subtracts c here
	} combine_t;

	typedef enum logic [2:0] {
		CNT_LZ  = 3'd0,
		CNT_POP = 3'd1,
		CNT_LO  = 3'd2,
		CNT_TZ  = 3'd3
	} countSel_t;

	typedef enum logic [7:0] {
		FLT_NONE  = 8'h00,
		FLT_CHK   = 8'h27,
		FLT_UNIMP = 8'h37
	} cause_t;

	// CHK codes, taken from func[3:0]
	// Codes 0..3: bit 1 makes the lower bound b exclusive, bit 0 the upper bound c inclusive
	localparam logic [3:0] CHK_RANGE_IN  = 4'd0;	// a must lie inside the range
	localparam logic [3:0] CHK_RANGE_OUT = 4'd4;	// Same ranges, a must lie outside
	localparam logic [3:0] CHK_CPL_GE    = 4'd8;
	localparam logic [3:0] CHK_CPL_LE    = 4'd9;
	localparam logic [3:0] CHK_CANARY    = 4'd10;

endpackage

`default_nettype wire

/* verilog/sauShifter.sv */
`default_nettype none

module sauShifter import sauPkg::*; #(
	parameter int Width = DefaultWidth
)(
	input  logic [Width-1:0] a,
	input  logic [Width-1:0] b,
	output logic [Width-1:0] shl,
	output logic [Width-1:0] lsr,
	output logic [Width-1:0] asr,
	output logic [Width-1:0] rol,
	output logic [Width-1:0] ror
);

	localparam int AmtW = $clog2(Width);

	logic [AmtW-1:0] amt;
	logic [2*Width-1:0] rolWide;
	logic [2*Width-1:0] rorWide;
	logic [2*Width-1:0] undoWide;

	assign amt = b[AmtW-1:0];	// Upper bits of b are ignored

	always_comb
	begin
		shl = a << amt;
		lsr = a >> amt;
		asr = $signed(a) >>> amt;	// Sign fills from the top

		// Doubled copy of a so that the bits shifted out wrap around
		rolWide = {a, a} << amt;
		rorWide = {a, a} >> amt;
		rol = rolWide[2*Width-1:Width];
		ror = rorWide[Width-1:0];

		// A right rotate by the same amount must undo the left rotate
		undoWide = {rol, rol} >> amt;
		if (!$isunknown({a, b}))
		begin
			assert (undoWide[Width-1:0] == a)
				else $error("sauShifter: rotate round trip gave %h for a=%h amt=%0d",
					undoWide[Width-1:0], a, amt);
		end
	end

endmodule

`default_nettype wire

/* verilog/sauTop.sv */
`default_nettype none

module sauTop import sauPkg::*; #(
	parameter int Width = DefaultWidth
)(
	input  logic clk,
	input  logic rst,
	input  logic inValid,
	input  opcode_t opcode,
	input  func_t func,
	input  logic [2:0] op3,
	input  logic [Width-1:0] a,
	input  logic [Width-1:0] b,
	input  logic [Width-1:0] c,
	input  logic [Width-1:0] imm,
	input  logic [7:0] cpl,
	input  logic [Width-1:0] canary,
	output logic outValid,
	output logic [Width-1:0] o,
	output cause_t excOut
);

	logic [Width-1:0] shl;
	logic [Width-1:0] lsr;
	logic [Width-1:0] asr;
	logic [Width-1:0] rol;
	logic [Width-1:0] ror;
	logic [$clog2(Width):0] lzCnt;
	logic [$clog2(Width):0] loCnt;
	logic [$clog2(Width):0] tzCnt;
	logic [$clog2(Width):0] popCnt;
	cause_t chkCause;

	// Combinational units feed the single register stage in sauExecute
	sauShifter #(.Width(Width)) uShifter (
		.a(a),
		.b(b),
		.shl(shl),
		.lsr(lsr),
		.asr(asr),
		.rol(rol),
		.ror(ror)
	);

	sauBitCount #(.Width(Width)) uBitCount (
		.a(a),
		.lzCnt(lzCnt),
		.loCnt(loCnt),
		.tzCnt(tzCnt),
		.popCnt(popCnt)
	);

	sauChecker #(.Width(Width)) uChecker (
		.opcode(opcode),
		.func(func),
		.a(a),
		.b(b),
		.c(c),
		.canary(canary),
		.cpl(cpl),
		.chkCause(chkCause)
	);

	sauExecute #(.Width(Width)) uExecute (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.opcode(opcode),
		.func(func),
		.op3(op3),
		.a(a),
		.b(b),
		.c(c),
		.imm(imm),
		.shl(shl),
		.lsr(lsr),
		.asr(asr),
		.rol(rol),
		.ror(ror),
		.lzCnt(lzCnt),
		.loCnt(loCnt),
		.tzCnt(tzCnt),
		.popCnt(popCnt),
		.chkCause(chkCause),
		.outValid(outValid),
		.o(o),
		.excOut(excOut)
	);

endmodule

`default_nettype wire
